/* dcmp_pkg.sv */
package dcmp_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int unsigned COEFF_W         = 23;
    localparam int unsigned HIGH_W          = 6;
    localparam int unsigned COEFFS_PER_WORD = 4;
    localparam int unsigned POLY_WORDS      = 4;
    localparam int unsigned NUM_POLY        = 2;
    localparam int unsigned RUN_WORDS       = NUM_POLY * POLY_WORDS;
    localparam int unsigned ADDR_W          = 10;

    // ------------------------------
    // Vector types
    // ------------------------------
    typedef logic [COEFF_W-1:0]                 coeff_t;
    typedef logic [HIGH_W-1:0]                  high_t;
    typedef logic [ADDR_W-1:0]                  mem_addr_t;
    // Coefficient 0 sits in the low bits of both word types
    typedef logic [COEFFS_PER_WORD*COEFF_W-1:0] mem_word_t;
    typedef logic [COEFFS_PER_WORD*HIGH_W-1:0]  high_word_t;

    // Field constants
    localparam coeff_t DCMP_Q      = 23'd8380417;
    localparam coeff_t DCMP_GAMMA2 = 23'd95232;
    // 2*GAMMA2, the step between neighbouring r1 values
    localparam coeff_t DCMP_ALPHA  = 23'd190464;

    // ------------------------------
    // Enums
    // ------------------------------
    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } rw_op_e;

    typedef enum logic {
        DCMP_RD_IDLE,
        DCMP_RD_MEM
    } dcmp_rd_state_e;

    typedef enum logic {
        DCMP_WR_IDLE,
        DCMP_WR_MEM
    } dcmp_wr_state_e;

    // ------------------------------
    // Structs
    // ------------------------------
    typedef struct packed {
        rw_op_e    rw_op;
        mem_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        mem_word_t  r0_word;
        high_word_t high_word;
    } dcmp_result_t;

endpackage

/* decompose_ctrl.sv */
`timescale 1ns/1ps

module decompose_ctrl (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize,
    input  logic                decompose_enable,
    input  dcmp_pkg::mem_addr_t src_base_addr,
    input  dcmp_pkg::mem_addr_t dest_base_addr,
    input  logic                r0_ready,
    output dcmp_pkg::mem_req_t  mem_rd_req,
    output dcmp_pkg::mem_req_t  mem_wr_req,
    output logic                mod_enable,
    output logic                decompose_done
);

    dcmp_pkg::dcmp_rd_state_e rd_state, rd_state_nxt;
    dcmp_pkg::dcmp_wr_state_e wr_state, wr_state_nxt;

    dcmp_pkg::mem_addr_t rd_addr, wr_addr;
    dcmp_pkg::mem_addr_t rd_offset, wr_offset;
    logic                rd_last, wr_last;
    logic                start_run;
    logic                start_write;

    // ------------------------------
    // Run bookkeeping
    // ------------------------------
    // Offsets are taken modulo the address width so a run may wrap
    assign rd_offset = rd_addr - src_base_addr;
    assign wr_offset = wr_addr - dest_base_addr;
    assign rd_last   = (rd_offset == dcmp_pkg::mem_addr_t'(dcmp_pkg::RUN_WORDS - 1));
    assign wr_last   = (wr_offset == dcmp_pkg::mem_addr_t'(dcmp_pkg::RUN_WORDS - 1));

    assign decompose_done = (rd_state == dcmp_pkg::DCMP_RD_IDLE) &&
                            (wr_state == dcmp_pkg::DCMP_WR_IDLE);

    // A new run only starts once the previous one has fully drained
    assign start_run   = decompose_enable && decompose_done;
    // First stage-1 result of the sweep opens the write window
    assign start_write = r0_ready && (rd_state == dcmp_pkg::DCMP_RD_MEM);

    // ------------------------------
    // Read side
    // ------------------------------
    always_comb begin
        rd_state_nxt = rd_state;
        case (rd_state)
            dcmp_pkg::DCMP_RD_IDLE: begin
                if (start_run) begin
                    rd_state_nxt = dcmp_pkg::DCMP_RD_MEM;
                end
            end
            dcmp_pkg::DCMP_RD_MEM: begin
                if (rd_last) begin
                    rd_state_nxt = dcmp_pkg::DCMP_RD_IDLE;
                end
            end
            default: rd_state_nxt = dcmp_pkg::DCMP_RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_state <= dcmp_pkg::DCMP_RD_IDLE;
            rd_addr  <= '0;
        end else if (zeroize) begin
            rd_state <= dcmp_pkg::DCMP_RD_IDLE;
            rd_addr  <= '0;
        end else begin
            rd_state <= rd_state_nxt;
            // Idle keeps the base loaded so the first read goes out at once
            if (rd_state == dcmp_pkg::DCMP_RD_IDLE) begin
                rd_addr <= src_base_addr;
            end else if (!rd_last) begin
                rd_addr <= rd_addr + dcmp_pkg::mem_addr_t'(1);
            end
        end
    end

    // ------------------------------
    // Write side
    // ------------------------------
    always_comb begin
        wr_state_nxt = wr_state;
        case (wr_state)
            dcmp_pkg::DCMP_WR_IDLE: begin
                if (start_write) begin
                    wr_state_nxt = dcmp_pkg::DCMP_WR_MEM;
                end
            end
            dcmp_pkg::DCMP_WR_MEM: begin
                if (wr_last) begin
                    wr_state_nxt = dcmp_pkg::DCMP_WR_IDLE;
                end
            end
            default: wr_state_nxt = dcmp_pkg::DCMP_WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_state <= dcmp_pkg::DCMP_WR_IDLE;
            wr_addr  <= '0;
        end else if (zeroize) begin
            wr_state <= dcmp_pkg::DCMP_WR_IDLE;
            wr_addr  <= '0;
        end else begin
            wr_state <= wr_state_nxt;
            if (wr_state == dcmp_pkg::DCMP_WR_IDLE) begin
                wr_addr <= dest_base_addr;
            end else if (!wr_last) begin
                wr_addr <= wr_addr + dcmp_pkg::mem_addr_t'(1);
            end
        end
    end

    // Requests
    assign mod_enable       = (rd_state == dcmp_pkg::DCMP_RD_MEM);
    assign mem_rd_req.rw_op = mod_enable ? dcmp_pkg::RW_READ : dcmp_pkg::RW_IDLE;
    assign mem_rd_req.addr  = rd_addr;
    assign mem_wr_req.rw_op = (wr_state == dcmp_pkg::DCMP_WR_MEM) ? dcmp_pkg::RW_WRITE
                                                                  : dcmp_pkg::RW_IDLE;
    assign mem_wr_req.addr  = wr_addr;

    // A read follows an accepted start or an earlier read that was not the last one
    assert property (@(posedge clk) disable iff (!reset_n)
        (mem_rd_req.rw_op == dcmp_pkg::RW_READ) |->
            (rd_state != dcmp_pkg::DCMP_RD_IDLE) &&
            ($past(start_run) || $past(mod_enable && !rd_last)));

    assert property (@(posedge clk) disable iff (!reset_n)
        (rd_state == dcmp_pkg::DCMP_RD_MEM) |->
            (rd_offset <= dcmp_pkg::mem_addr_t'(dcmp_pkg::RUN_WORDS - 1)));

    assert property (@(posedge clk) disable iff (!reset_n)
        (wr_state == dcmp_pkg::DCMP_WR_MEM) |->
            (wr_offset <= dcmp_pkg::mem_addr_t'(dcmp_pkg::RUN_WORDS - 1)));

endmodule

/* decompose_lane.sv */
`timescale 1ns/1ps

module decompose_lane (
    input  logic             clk,
    input  logic             reset_n,
    input  dcmp_pkg::coeff_t coeff_in,
    output dcmp_pkg::coeff_t r0_out,
    output dcmp_pkg::high_t  r1_out
);

    dcmp_pkg::coeff_t                    residue;
    logic signed [dcmp_pkg::COEFF_W:0]   centered_nxt;
    dcmp_pkg::coeff_t                    r_q;
    logic signed [dcmp_pkg::COEFF_W:0]   centered_q;
    logic signed [dcmp_pkg::COEFF_W+1:0] diff;
    logic        [dcmp_pkg::COEFF_W+1:0] quot;
    logic                                corner;
    logic signed [dcmp_pkg::COEFF_W:0]   r0_signed;
    logic signed [dcmp_pkg::COEFF_W:0]   r0_adj;

    // ------------------------------
    // Stage 1, centered r mod 2*GAMMA2
    // ------------------------------
    assign residue      = coeff_in % dcmp_pkg::DCMP_ALPHA;
    assign centered_nxt = (residue > dcmp_pkg::DCMP_GAMMA2) ?
                          $signed({1'b0, residue}) - $signed({1'b0, dcmp_pkg::DCMP_ALPHA}) :
                          $signed({1'b0, residue});

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r_q        <= '0;
            centered_q <= '0;
        end else begin
            r_q        <= coeff_in;
            centered_q <= centered_nxt;
        end
    end

    // ------------------------------
    // Stage 2, high part and final r0
    // ------------------------------
    // r minus r0 is an exact multiple of 2*GAMMA2
    assign diff   = $signed({2'b00, r_q}) - centered_q;
    assign quot   = $unsigned(diff) / {2'b00, dcmp_pkg::DCMP_ALPHA};
    // Q-1 would give r1 = 44, which folds back to 0
    assign corner = (diff == $signed({2'b00, dcmp_pkg::DCMP_Q - 23'd1}));

    assign r0_signed = corner ? centered_q - (dcmp_pkg::COEFF_W+1)'(1) : centered_q;
    assign r0_adj    = r0_signed[dcmp_pkg::COEFF_W] ?
                       r0_signed + $signed({1'b0, dcmp_pkg::DCMP_Q}) : r0_signed;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            r0_out <= '0;
            r1_out <= '0;
        end else begin
            r0_out <= r0_adj[dcmp_pkg::COEFF_W-1:0];
            r1_out <= corner ? '0 : quot[dcmp_pkg::HIGH_W-1:0];
        end
    end

    // Holds for every 23-bit input, not only reduced ones
    assert property (@(posedge clk) disable iff (!reset_n)
        r1_out <= dcmp_pkg::high_t'(43));

endmodule

/* decompose_top.sv */
`timescale 1ns/1ps

module decompose_top (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize,
    input  logic                 decompose_enable,
    input  dcmp_pkg::mem_addr_t  src_base_addr,
    input  dcmp_pkg::mem_addr_t  dest_base_addr,
    input  dcmp_pkg::mem_word_t  rd_data,
    output dcmp_pkg::mem_req_t   mem_rd_req,
    output dcmp_pkg::mem_req_t   mem_wr_req,
    output dcmp_pkg::mem_word_t  wr_data,
    output dcmp_pkg::high_word_t high_word,
    output logic                 decompose_done
);

    logic                   mod_enable;
    logic                   r0_ready;
    dcmp_pkg::dcmp_result_t result;

    decompose_ctrl i_decompose_ctrl (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .decompose_enable (decompose_enable),
        .src_base_addr    (src_base_addr),
        .dest_base_addr   (dest_base_addr),
        .r0_ready         (r0_ready),
        .mem_rd_req       (mem_rd_req),
        .mem_wr_req       (mem_wr_req),
        .mod_enable       (mod_enable),
        .decompose_done   (decompose_done)
    );

    decompose_unit i_decompose_unit (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .mod_enable (mod_enable),
        .rd_data    (rd_data),
        .r0_ready   (r0_ready),
        .result     (result)
    );

    // Write data lines up with the write request of the same cycle
    assign wr_data   = result.r0_word;
    assign high_word = result.high_word;

endmodule

/* decompose_trace.txt */
// Run header: src_base dest_base
// Word line: c0 c1 c2 c3 source, r0 of c0..c3 expected, r1 of c0..c3 expected
// run 0
000 100
000000 7fe000 017400 017401  000000 7fe000 017400 7e6c02  00 00 00 01
02e800 5d0000 7cf800 1d1000  000000 000000 000000 000000  01 20 2b 0a
0ffc00 15cc01 3a2123 3a1edd  017400 7e6c02 000123 7fdede  05 08 14 14
233555 228aab 694bcd 67f433  005555 7f8aac 00abcd 7f3434  0c 0c 24 24
7e6c00 7e6c01 7fdfff 7f0000  017400 7e6c01 7fdfff 7f0000  2b 00 00 00
60e800 5ee800 1b9800 18b800  010000 7ee001 017000 7e7001  21 21 09 09
2e9000 2e7000 7a1001 7a0fff  001000 7fd001 000001 7fe000  10 10 2a 2a
000001 02e7ff 473400 4a1c01  000001 7fe000 017400 7e6c02  00 01 18 1a
// run 1, destination wraps past the top of memory
040 3fc
4a1c01 7e6c00 7fe000 0ffc00  7e6c02 017400 7fe000 017400  1a 2b 00 05
7a0fff 000000 7f0000 233555  7fe000 000000 7f0000 005555  2a 00 00 0c
017401 18b800 3a2123 02e7ff  7e6c02 7e7001 000123 7fe000  01 09 14 01
7cf800 67f433 7fdfff 2e9000  000000 7f3434 7fdfff 001000  2b 24 00 10
5ee800 017400 000001 15cc01  7ee001 017400 000001 7e6c02  21 00 00 08
228aab 7a1001 02e800 7e6c01  7f8aac 000001 000000 7e6c01  0c 2a 01 00
473400 1d1000 60e800 3a1edd  017400 000000 010000 7fdede  18 0a 21 14
694bcd 2e7000 5d0000 1b9800  00abcd 7fd001 000000 017000  24 10 20 09
// run 2
2a5 123
7fe000 7fe000 7fe000 7fe000  7fe000 7fe000 7fe000 7fe000  00 00 00 00
7e6c01 7fdfff 7f0000 7fe000  7e6c01 7fdfff 7f0000 7fe000  00 00 00 00
5d0000 02e800 1d1000 7cf800  000000 000000 000000 000000  20 01 0a 2b
000000 017400 017401 000001  000000 017400 7e6c02 000001  00 00 01 00
3a1edd 3a2123 228aab 233555  7fdede 000123 7f8aac 005555  14 14 0c 0c
18b800 1b9800 5ee800 60e800  7e7001 017000 7ee001 010000  09 09 21 21
02e7ff 7a0fff 7a1001 2e7000  7fe000 7fe000 000001 7fd001  01 2a 2a 10
15cc01 0ffc00 4a1c01 473400  7e6c02 017400 7e6c02 017400  08 05 1a 18

/* decompose_unit.sv */
`timescale 1ns/1ps

module decompose_unit (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  logic                   mod_enable,
    input  dcmp_pkg::mem_word_t    rd_data,
    output logic                   r0_ready,
    output dcmp_pkg::dcmp_result_t result
);

    // Bit 0 marks rd_data valid, bit 1 stage 1, bit 2 stage 2
    logic [2:0]           valid_pipe;
    dcmp_pkg::mem_word_t  r0_word;
    dcmp_pkg::high_word_t high_word;

    // ------------------------------
    // Valid tracking
    // ------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_pipe <= '0;
        end else if (zeroize) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[1:0], mod_enable};
        end
    end

    // One cycle ahead of the result, so the write FSM can get going
    assign r0_ready = valid_pipe[1];

    // ------------------------------
    // Lanes
    // ------------------------------
    for (genvar g = 0; g < dcmp_pkg::COEFFS_PER_WORD; g++) begin : g_lane
        decompose_lane i_lane (
            .clk      (clk),
            .reset_n  (reset_n),
            .coeff_in (rd_data[g*dcmp_pkg::COEFF_W +: dcmp_pkg::COEFF_W]),
            .r0_out   (r0_word[g*dcmp_pkg::COEFF_W +: dcmp_pkg::COEFF_W]),
            .r1_out   (high_word[g*dcmp_pkg::HIGH_W +: dcmp_pkg::HIGH_W])
        );
    end

    // Quiet outputs between words
    always_comb begin
        if (valid_pipe[2]) begin
            result.r0_word   = r0_word;
            result.high_word = high_word;
        end else begin
            result.r0_word   = '0;
            result.high_word = '0;
        end
    end

endmodule

/* src.f */
dcmp_pkg.sv
decompose_lane.sv
decompose_unit.sv
decompose_ctrl.sv
decompose_top.sv
tb_decompose.sv

/* tb_decompose.sv */
`timescale 1ns/1ps

module tb_decompose;

    localparam int RESET_CYCLES = 5;
    // Edge E samples the start, done is back high in cycle E+12
    localparam int RUN_CYCLES   = 12;
    localparam int FIRST_WRITE  = 4;
    // Three trace runs, one cut short by zeroize and one rerun after it
    localparam int NUM_STARTS   = 5;
    localparam int TIMEOUT      = RESET_CYCLES + NUM_STARTS * (RUN_CYCLES + 1) + 60;
    localparam int LINE_LEN     = 12;
    localparam int RUN_LEN      = 2 + dcmp_pkg::RUN_WORDS * LINE_LEN;
    localparam int TRACE_LEN    = 3 * RUN_LEN;

    logic                 clk;
    logic                 reset_n;
    logic                 zeroize;
    logic                 decompose_enable;
    dcmp_pkg::mem_addr_t  src_base_addr;
    dcmp_pkg::mem_addr_t  dest_base_addr;
    dcmp_pkg::mem_word_t  rd_data;
    dcmp_pkg::mem_req_t   mem_rd_req;
    dcmp_pkg::mem_req_t   mem_wr_req;
    dcmp_pkg::mem_word_t  wr_data;
    dcmp_pkg::high_word_t high_word;
    logic                 decompose_done;

    logic [23:0]         trace_mem [0:TRACE_LEN-1];
    dcmp_pkg::mem_word_t src_mem [0:(1 << dcmp_pkg::ADDR_W)-1];

    int cycle_count;
    int check_count;
    int total_checks;
    int test_errors;
    int total_errors;
    int test_count;
    int write_count;

    decompose_top i_decompose_top (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .decompose_enable (decompose_enable),
        .src_base_addr    (src_base_addr),
        .dest_base_addr   (dest_base_addr),
        .rd_data          (rd_data),
        .mem_rd_req       (mem_rd_req),
        .mem_wr_req       (mem_wr_req),
        .wr_data          (wr_data),
        .high_word        (high_word),
        .decompose_done   (decompose_done)
    );

    always #4 clk = ~clk;

    // ------------------------------
    // Memory model and watchdog
    // ------------------------------
    // Read data follows the request by one cycle
    initial begin : memory_model
        logic                pend_valid;
        dcmp_pkg::mem_addr_t pend_addr;
        pend_valid = 1'b0;
        pend_addr  = '0;
        rd_data    = '0;
        forever begin
            @(negedge clk);
            rd_data    = pend_valid ? src_mem[pend_addr] : '0;
            pend_valid = (mem_rd_req.rw_op == dcmp_pkg::RW_READ);
            pend_addr  = mem_rd_req.addr;
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Errors found");
        $finish;
    end

    // ------------------------------
    // Trace access
    // ------------------------------
    // Column group 0 is the source word, 1 the expected r0 word
    function automatic dcmp_pkg::mem_word_t trace_word(input int run, input int line,
                                                       input int col);
        dcmp_pkg::mem_word_t w;
        int                  base;
        base = run * RUN_LEN + 2 + line * LINE_LEN + col * dcmp_pkg::COEFFS_PER_WORD;
        for (int c = 0; c < dcmp_pkg::COEFFS_PER_WORD; c++) begin
            w[c*dcmp_pkg::COEFF_W +: dcmp_pkg::COEFF_W] =
                trace_mem[base + c][dcmp_pkg::COEFF_W-1:0];
        end
        return w;
    endfunction

    function automatic dcmp_pkg::high_word_t trace_high(input int run, input int line);
        dcmp_pkg::high_word_t h;
        int                   base;
        base = run * RUN_LEN + 2 + line * LINE_LEN + 2 * dcmp_pkg::COEFFS_PER_WORD;
        for (int c = 0; c < dcmp_pkg::COEFFS_PER_WORD; c++) begin
            h[c*dcmp_pkg::HIGH_W +: dcmp_pkg::HIGH_W] = trace_mem[base + c][dcmp_pkg::HIGH_W-1:0];
        end
        return h;
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic expect_idle();
        compare_value("mem_rd_req.rw_op", mem_rd_req.rw_op, dcmp_pkg::RW_IDLE);
        compare_value("mem_wr_req.rw_op", mem_wr_req.rw_op, dcmp_pkg::RW_IDLE);
        compare_value("decompose_done", decompose_done, 1'b1);
        if (mem_wr_req.rw_op == dcmp_pkg::RW_WRITE) begin
            write_count++;
        end
    endtask

    // Cycle E+k of a run
    task automatic verify_run_cycle(input int run, input int k, input dcmp_pkg::mem_addr_t src,
                                    input dcmp_pkg::mem_addr_t dest);
        dcmp_pkg::mem_addr_t exp_addr;
        int                  w;
        w = k - FIRST_WRITE;
        if (k >= 1 && k <= dcmp_pkg::RUN_WORDS) begin
            exp_addr = src + dcmp_pkg::mem_addr_t'(k - 1);
            compare_value("mem_rd_req.rw_op", mem_rd_req.rw_op, dcmp_pkg::RW_READ);
            compare_value("mem_rd_req.addr", mem_rd_req.addr, exp_addr);
        end else begin
            compare_value("mem_rd_req.rw_op", mem_rd_req.rw_op, dcmp_pkg::RW_IDLE);
        end
        if (w >= 0 && w < dcmp_pkg::RUN_WORDS) begin
            exp_addr = dest + dcmp_pkg::mem_addr_t'(w);
            compare_value("mem_wr_req.rw_op", mem_wr_req.rw_op, dcmp_pkg::RW_WRITE);
            compare_value("mem_wr_req.addr", mem_wr_req.addr, exp_addr);
            compare_value("wr_data", wr_data, trace_word(run, w, 1));
            compare_value("high_word", high_word, trace_high(run, w));
        end else begin
            compare_value("mem_wr_req.rw_op", mem_wr_req.rw_op, dcmp_pkg::RW_IDLE);
        end
        compare_value("decompose_done", decompose_done, k >= RUN_CYCLES);
        if (mem_wr_req.rw_op == dcmp_pkg::RW_WRITE) begin
            write_count++;
        end
    endtask

    // ------------------------------
    // Runs
    // ------------------------------
    // The next rising edge is E, the caller drops the strobe one cycle later
    task automatic start_run(input int run, output dcmp_pkg::mem_addr_t src,
                             output dcmp_pkg::mem_addr_t dest);
        src  = trace_mem[run * RUN_LEN][dcmp_pkg::ADDR_W-1:0];
        dest = trace_mem[run * RUN_LEN + 1][dcmp_pkg::ADDR_W-1:0];
        for (int i = 0; i < dcmp_pkg::RUN_WORDS; i++) begin
            src_mem[src + dcmp_pkg::mem_addr_t'(i)] = trace_word(run, i, 0);
        end
        write_count      = 0;
        src_base_addr    = src;
        dest_base_addr   = dest;
        decompose_enable = 1'b1;
    endtask

    task automatic run_trace(input int run, input bit poke_enable);
        dcmp_pkg::mem_addr_t src;
        dcmp_pkg::mem_addr_t dest;
        start_run(run, src, dest);
        for (int k = 1; k <= RUN_CYCLES; k++) begin
            @(negedge clk);
            verify_run_cycle(run, k, src, dest);
            // Start pulse after the reads while writes still drain
            decompose_enable = poke_enable && (k == 9);
        end
        compare_value("write count", write_count, dcmp_pkg::RUN_WORDS);
    endtask

    task automatic zeroize_run(input int run);
        dcmp_pkg::mem_addr_t src;
        dcmp_pkg::mem_addr_t dest;
        start_run(run, src, dest);
        for (int k = 1; k <= 5; k++) begin
            @(negedge clk);
            verify_run_cycle(run, k, src, dest);
            decompose_enable = 1'b0;
        end
        // Reads and writes are both in flight here
        zeroize     = 1'b1;
        write_count = 0;
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            zeroize = 1'b0;
            expect_idle();
        end
        compare_value("writes after zeroize", write_count, 0);
    endtask

    task automatic end_test(input string name);
        $display("test %-14s %0d checks, %0d mismatches", name, check_count, test_errors);
        total_checks += check_count;
        total_errors += test_errors;
        test_count++;
        check_count = 0;
        test_errors = 0;
    endtask

    initial begin : stimulus
        clk              = 1'b0;
        reset_n          = 1'b0;
        zeroize          = 1'b0;
        decompose_enable = 1'b0;
        src_base_addr    = '0;
        dest_base_addr   = '0;
        check_count      = 0;
        total_checks     = 0;
        test_errors      = 0;
        total_errors     = 0;
        test_count       = 0;
        write_count      = 0;
        $readmemh("decompose_trace.txt", trace_mem);
        for (int a = 0; a < (1 << dcmp_pkg::ADDR_W); a++) begin
            src_mem[a] = {dcmp_pkg::COEFFS_PER_WORD{dcmp_pkg::coeff_t'(a)}};
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        assert (!$isunknown(trace_mem[TRACE_LEN-1])) else begin
            $display("trace file decompose_trace.txt is missing or too short");
            test_errors++;
        end
        expect_idle();
        end_test("reset_state");
        run_trace(0, 1'b0);
        end_test("sweep_run0");
        run_trace(1, 1'b1);
        end_test("enable_midrun");
        run_trace(2, 1'b0);
        end_test("back_to_back");
        zeroize_run(1);
        end_test("zeroize");
        run_trace(0, 1'b0);
        end_test("after_zeroize");
        $display("summary: %0d tests, %0d checks, %0d mismatches",
                 test_count, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
